// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_dc_line_doubler
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+dv
common/doubler_pkg.sv
capture/video_capture.sv
verilog/line_buffer.sv
output/video_output.sv
verilog/dc_line_doubler.sv
dv/tb_dc_line_doubler.sv

// ==== capture/video_capture.sv ====
`timescale 1ns/100ps

module video_capture #(
    parameter int H_START      = 32,
    parameter int H_ACTIVE     = 640,
    parameter int V_START      = 16,
    parameter int V_ACTIVE     = 480,
    parameter int BUFFER_LINES = 4
) (
    input  logic                            control_clock,
    input  logic                            reset_dc,
    input  logic                            hsync_n,
    input  logic                            vsync_n,
    input  logic [doubler_pkg::DATA_W-1:0]  data,
    output doubler_pkg::buffer_write_t      wr,
    output doubler_pkg::rgb_pixel_t         wr_pixel,
    output doubler_pkg::line_done_t         done
);
    import doubler_pkg::*;

    localparam int LINE_W = 12;
    localparam logic [X_W-1:0] X_FIRST = X_W'(H_START);
    localparam logic [X_W-1:0] X_LAST = X_W'(H_START + H_ACTIVE - 1);
    localparam logic [LINE_W-1:0] Y_FIRST = LINE_W'(V_START);
    localparam logic [LINE_W-1:0] Y_LAST = LINE_W'(V_START + V_ACTIVE - 1);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(BUFFER_LINES - 1);

    logic              hsync_q;
    logic              vsync_q;
    logic              hsync_fall;
    logic              vsync_fall;
    capture_phase_e    phase;
    logic [DATA_W-1:0] high_word;
    logic [X_W-1:0]    x_cnt;
    logic [LINE_W-1:0] line_cnt;
    logic [SLOT_W-1:0] slot;
    logic              in_window;
    logic              last_pixel;
    rgb_pixel_t        pixel;

    ////////////////////////////////////////
    // sync edges
    ////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
        end else begin
            hsync_q <= hsync_n;
            vsync_q <= vsync_n;
        end
    end

    assign hsync_fall = hsync_q & ~hsync_n;
    assign vsync_fall = vsync_q & ~vsync_n;

    ////////////////////////////////////////
    // position tracking
    ////////////////////////////////////////

    // the word sampled with the hsync edge is the first half of pixel 0
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            phase    <= PHASE_HIGH;
            x_cnt    <= '0;
            line_cnt <= '1;
            slot     <= '0;
        end else begin
            if (vsync_fall) begin
                line_cnt <= '0;
            end else if (hsync_fall && line_cnt != '1) begin
                line_cnt <= line_cnt + 1'b1;
            end

            if (hsync_fall) begin
                phase <= PHASE_LOW;
                x_cnt <= '0;
            end else if (phase == PHASE_HIGH) begin
                phase <= PHASE_LOW;
            end else begin
                phase <= PHASE_HIGH;
                // hold at the end, no wrap into a new window
                if (x_cnt != '1) begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end

            if (last_pixel) begin
                slot <= (slot == SLOT_LAST) ? '0 : slot + 1'b1;
            end
        end
    end

    always_ff @(posedge control_clock) begin
        if (hsync_fall || phase == PHASE_HIGH) begin
            high_word <= data;
        end
    end

    ////////////////////////////////////////
    // assembly and window
    ////////////////////////////////////////

    // second word completes the pixel
    assign in_window = !hsync_fall && phase == PHASE_LOW &&
                       x_cnt >= X_FIRST && x_cnt <= X_LAST &&
                       line_cnt >= Y_FIRST && line_cnt <= Y_LAST;
    assign last_pixel = in_window && x_cnt == X_LAST;

    assign pixel.red   = high_word[DATA_W-1:DATA_W-COLOR_W];
    assign pixel.green = {high_word[DATA_W-COLOR_W-1:0], data[DATA_W-1:COLOR_W]};
    assign pixel.blue  = data[COLOR_W-1:0];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            wr   <= '0;
            done <= '0;
        end else begin
            wr.wren             <= in_window;
            wr.slot             <= slot;
            wr.x                <= x_cnt - X_FIRST;
            done.strobe         <= last_pixel;
            done.slot           <= slot;
            done.first_of_frame <= line_cnt == Y_FIRST;
        end
    end

    always_ff @(posedge control_clock) begin
        wr_pixel <= pixel;
    end

endmodule

// ==== common/doubler_pkg.sv ====
package doubler_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    // console bus carries half a pixel per word
    localparam int DATA_W = 12;
    localparam int COLOR_W = 8;

    // buffer line index and pixel index
    localparam int SLOT_W = 8;
    localparam int X_W = 12;

    ////////////////////////////////////////
    // structs
    ////////////////////////////////////////

    typedef struct packed {
        logic [COLOR_W-1:0] red;
        logic [COLOR_W-1:0] green;
        logic [COLOR_W-1:0] blue;
    } rgb_pixel_t;

    // pixel data travels beside this on its own port
    typedef struct packed {
        logic              wren;
        logic [SLOT_W-1:0] slot;
        logic [X_W-1:0]    x;
    } buffer_write_t;

    typedef struct packed {
        logic              strobe;
        logic [SLOT_W-1:0] slot;
        logic              first_of_frame;
    } line_done_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        rgb_pixel_t pixel;
    } video_out_t;

    ////////////////////////////////////////
    // enums
    ////////////////////////////////////////

    // which half of a pixel comes next
    typedef enum logic {
        PHASE_HIGH,
        PHASE_LOW
    } capture_phase_e;

    typedef enum logic [2:0] {
        OUT_IDLE,
        OUT_SYNC,
        OUT_PORCH,
        OUT_ACTIVE,
        OUT_TAIL
    } output_state_e;

endpackage

// ==== dv/tb_frame_tasks.svh ====
////////////////////////////////////////
// frame stimulus and expected pixels
////////////////////////////////////////

// first word holds red and the upper green nibble
function automatic rgb_pixel_t join_words(input logic [11:0] first_word,
                                          input logic [11:0] second_word);
    rgb_pixel_t pixel;
    pixel.red   = first_word[11:4];
    pixel.green = {first_word[3:0], second_word[11:8]};
    pixel.blue  = second_word[7:0];
    return pixel;
endfunction

function automatic rgb_pixel_t halve_pixel(input rgb_pixel_t pixel);
    rgb_pixel_t dim;
    dim.red   = pixel.red >> 1;
    dim.green = pixel.green >> 1;
    dim.blue  = pixel.blue >> 1;
    return dim;
endfunction

// window pixels of line_words, twice in double mode
task automatic expect_window_line(input logic doubled, input logic dimmed);
    rgb_pixel_t line_pixels [H_ACTIVE];
    for (int k = 0; k < H_ACTIVE; k++) begin
        line_pixels[k] = join_words(line_words[2 * (H_START + k)],
                                    line_words[2 * (H_START + k) + 1]);
        expected_q.push_back(line_pixels[k]);
    end
    if (doubled) begin
        for (int k = 0; k < H_ACTIVE; k++) begin
            expected_q.push_back(dimmed ? halve_pixel(line_pixels[k]) : line_pixels[k]);
        end
    end
endtask

// vsync low for all of line 0, hsync low for hblank cycles per line
task automatic drive_frames(input int frames, input int hblank,
                            input logic doubled, input logic dimmed);
    for (int f = 0; f < frames; f++) begin
        for (int l = 0; l < FRAME_LINES; l++) begin
            for (int c = 0; c < IN_LINE_CYCLES; c++) begin
                line_words[c] = DATA_W'($urandom);
            end
            if (l >= V_START && l < V_START + V_ACTIVE) begin
                expect_window_line(doubled, dimmed);
            end
            for (int c = 0; c < IN_LINE_CYCLES; c++) begin
                @(posedge control_clock);
                hsync_n <= (c >= hblank);
                vsync_n <= (l != 0);
                data    <= line_words[c];
                if (l == V_START && c == 2 * (H_START + H_ACTIVE) - 1) begin
                    window_driven = 1'b1;
                end
            end
        end
    end
    @(posedge control_clock);
    hsync_n <= 1'b1;
    vsync_n <= 1'b1;
    data    <= '0;
    drive_finished = 1'b1;
endtask

// ==== dv/tb_dc_line_doubler.sv ====
`timescale 1ns/100ps

module tb_dc_line_doubler;
    import doubler_pkg::*;

    localparam int H_START         = 4;
    localparam int H_ACTIVE        = 8;
    localparam int V_START         = 2;
    localparam int V_ACTIVE        = 3;
    localparam int BUFFER_LINES    = 4;
    localparam int OUT_LINE_CYCLES = 24;
    localparam int OUT_SYNC_CYCLES = 2;
    localparam int IN_LINE_CYCLES  = 64;
    localparam int FRAME_LINES     = 6;
    localparam int RESET_CYCLES    = 8;
    localparam int SETTLE_CYCLES   = 4 * OUT_LINE_CYCLES;
    localparam int ROW_COUNT       = 4;

    typedef struct packed {
        logic line_double;
        logic scanline_en;
        int   frames;
        int   hblank;
    } test_row_t;

    logic              control_clock;
    logic              reset_dc;
    logic              hsync_n;
    logic              vsync_n;
    logic [DATA_W-1:0] data;
    logic              line_double;
    logic              scanline_en;
    video_out_t        video;

    test_row_t         row_table [ROW_COUNT];
    logic [DATA_W-1:0] line_words [IN_LINE_CYCLES];
    rgb_pixel_t        expected_q [$];
    logic              window_driven;
    logic              drive_finished;
    int                error_count;
    int                check_count;

    dc_line_doubler #(
        .H_START         (H_START),
        .H_ACTIVE        (H_ACTIVE),
        .V_START         (V_START),
        .V_ACTIVE        (V_ACTIVE),
        .BUFFER_LINES    (BUFFER_LINES),
        .OUT_LINE_CYCLES (OUT_LINE_CYCLES),
        .OUT_SYNC_CYCLES (OUT_SYNC_CYCLES)
    ) dc_line_doubler_i (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .hsync_n       (hsync_n),
        .vsync_n       (vsync_n),
        .data          (data),
        .line_double   (line_double),
        .scanline_en   (scanline_en),
        .video         (video)
    );

    initial begin
        control_clock = 1'b0;
        forever #5 control_clock = ~control_clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("mismatch %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        error_count++;
    endtask

    `include "tb_frame_tasks.svh"

    // idle raster expected while reset is held
    task automatic reset_dut(input logic doubled, input logic dimmed);
        @(posedge control_clock);
        reset_dc    <= 1'b1;
        hsync_n     <= 1'b1;
        vsync_n     <= 1'b1;
        data        <= '0;
        line_double <= doubled;
        scanline_en <= dimmed;
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(posedge control_clock);
            @(negedge control_clock);
            check_value("video.hsync", 32'(video.hsync), 32'h1);
            check_value("video.vsync", 32'(video.vsync), 32'h1);
            check_value("video.de", 32'(video.de), 32'h0);
            check_value("video.pixel", 32'(video.pixel), 32'h0);
        end
        @(posedge control_clock);
        reset_dc <= 1'b0;
    endtask

    ////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////

    task automatic collect_video(input int expected_total, input int frames);
        int         limit;
        int         cycles;
        int         settle;
        int         seen;
        int         per_frame;
        int         vsync_pulses;
        int         hsync_fall_cycle;
        int         run_length;
        logic       hsync_prev;
        logic       vsync_prev;
        logic       de_prev;
        rgb_pixel_t want;
        limit = frames * FRAME_LINES * IN_LINE_CYCLES + 16 * OUT_LINE_CYCLES;
        per_frame = expected_total / frames;
        cycles = 0;
        settle = 0;
        seen = 0;
        vsync_pulses = 0;
        hsync_fall_cycle = 0;
        run_length = 0;
        hsync_prev = 1'b1;
        vsync_prev = 1'b1;
        de_prev = 1'b0;
        while (settle < SETTLE_CYCLES && cycles < limit) begin
            @(negedge control_clock);
            cycles++;
            if (hsync_prev && !video.hsync) begin
                hsync_fall_cycle = cycles;
            end
            // a frame mark comes before any of that frame's pixels
            if (vsync_prev && !video.vsync) begin
                check_value("vsync position", seen, vsync_pulses * per_frame);
                vsync_pulses++;
            end
            if (video.de) begin
                if (!de_prev) begin
                    check_value("de offset", cycles - hsync_fall_cycle, 2 * OUT_SYNC_CYCLES);
                end
                if (!window_driven) begin
                    report_failure("de went high before a full window line was driven");
                end
                run_length++;
                if (expected_q.size() == 0) begin
                    report_failure("de pixel seen with no pixel left to expect");
                end else begin
                    want = expected_q.pop_front();
                    check_value("video.pixel", 32'(video.pixel), 32'(want));
                end
                seen++;
            end else if (de_prev) begin
                check_value("de run length", run_length, H_ACTIVE);
                run_length = 0;
            end
            hsync_prev = video.hsync;
            vsync_prev = video.vsync;
            de_prev = video.de;
            if (drive_finished && seen >= expected_total) begin
                settle++;
            end
        end
        if (settle < SETTLE_CYCLES) begin
            report_failure("timed out waiting for the output pixels of a row");
        end
        check_value("vsync pulses", vsync_pulses, frames);
        check_value("pixel count", seen, expected_total);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        int row_errors;
        int row_pixels;
        reset_dc = 1'b1;
        hsync_n = 1'b1;
        vsync_n = 1'b1;
        data = '0;
        line_double = 1'b0;
        scanline_en = 1'b0;
        window_driven = 1'b0;
        drive_finished = 1'b0;
        error_count = 0;
        check_count = 0;
        void'($urandom(32'h3d48));

        // line_double, scanline_en, frames, hsync low cycles
        row_table[0] = '{1'b0, 1'b0, 2, 4};
        row_table[1] = '{1'b1, 1'b0, 2, 6};
        row_table[2] = '{1'b1, 1'b1, 2, 10};
        row_table[3] = '{1'b0, 1'b1, 1, 2};

        for (int r = 0; r < ROW_COUNT; r++) begin
            row_errors = error_count;
            expected_q.delete();
            window_driven = 1'b0;
            drive_finished = 1'b0;
            reset_dut(row_table[r].line_double, row_table[r].scanline_en);
            row_pixels = row_table[r].frames * V_ACTIVE * H_ACTIVE *
                         (row_table[r].line_double ? 2 : 1);
            fork
                drive_frames(row_table[r].frames, row_table[r].hblank,
                             row_table[r].line_double, row_table[r].scanline_en);
                collect_video(row_pixels, row_table[r].frames);
            join
            $display("row %0d line_double=%0d scanline_en=%0d frames=%0d pixels=%0d errors=%0d",
                     r, row_table[r].line_double, row_table[r].scanline_en,
                     row_table[r].frames, row_pixels, error_count - row_errors);
        end

        $display("rows %0d checks %0d errors %0d", ROW_COUNT, check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== output/video_output.sv ====
`timescale 1ns/100ps

module video_output #(
    parameter int H_ACTIVE        = 640,
    parameter int BUFFER_LINES    = 4,
    parameter int OUT_LINE_CYCLES = 858,
    parameter int OUT_SYNC_CYCLES = 62
) (
    input  logic                           control_clock,
    input  logic                           reset_dc,
    input  doubler_pkg::line_done_t        done,
    input  logic                           line_double,
    input  logic                           scanline_en,
    output logic [doubler_pkg::SLOT_W-1:0] rd_slot,
    output logic [doubler_pkg::X_W-1:0]    rd_x,
    input  doubler_pkg::rgb_pixel_t        rd_pixel,
    output doubler_pkg::video_out_t        video
);
    import doubler_pkg::*;

    localparam int HC_W = $clog2(OUT_LINE_CYCLES);
    localparam int PEND_W = $clog2(BUFFER_LINES + 1);
    localparam int IDX_W = $clog2(BUFFER_LINES);
    localparam int ACT_START = 2 * OUT_SYNC_CYCLES;
    localparam logic [HC_W-1:0] H_LAST = HC_W'(OUT_LINE_CYCLES - 1);
    localparam logic [HC_W-1:0] SYNC_LAST = HC_W'(OUT_SYNC_CYCLES - 1);
    localparam logic [HC_W-1:0] PORCH_LAST = HC_W'(ACT_START - 1);
    localparam logic [HC_W-1:0] ACTIVE_LAST = HC_W'(ACT_START + H_ACTIVE - 1);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(BUFFER_LINES - 1);

    output_state_e           state;
    output_state_e           state_next;
    logic [HC_W-1:0]         h_cnt;
    logic                    line_start;
    logic [PEND_W-1:0]       pend_cnt;
    logic [BUFFER_LINES-1:0] first_flags;
    logic [SLOT_W-1:0]       slot_q;
    logic [SLOT_W-1:0]       slot_next;
    logic [SLOT_W-1:0]       take_slot;
    logic                    line_active;
    logic                    second_copy;
    logic                    show_first;
    logic                    repeat_line;
    logic                    release_line;
    logic                    take_line;
    logic                    hsync_q;
    logic                    vsync_q;
    logic                    de_q;
    logic                    dim_q;
    rgb_pixel_t              pixel_dim;

    ////////////////////////////////////////
    // line timing
    ////////////////////////////////////////

    assign line_start = h_cnt == H_LAST;

    // first edge after reset opens a line
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            h_cnt <= H_LAST;
            state <= OUT_IDLE;
        end else begin
            h_cnt <= line_start ? '0 : h_cnt + 1'b1;
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            OUT_SYNC: begin
                if (h_cnt == SYNC_LAST) begin
                    state_next = OUT_PORCH;
                end
            end
            OUT_PORCH: begin
                if (h_cnt == PORCH_LAST) begin
                    state_next = line_active ? OUT_ACTIVE : OUT_IDLE;
                end
            end
            OUT_ACTIVE: begin
                if (h_cnt == ACTIVE_LAST) begin
                    state_next = OUT_TAIL;
                end
            end
            default: begin
                state_next = state;
            end
        endcase
        if (line_start) begin
            state_next = OUT_SYNC;
        end
    end

    ////////////////////////////////////////
    // pending lines
    ////////////////////////////////////////

    // the line on screen stays counted until released
    assign repeat_line = line_active && line_double && !second_copy;
    assign release_line = line_start && line_active && !repeat_line;
    assign slot_next = (slot_q == SLOT_LAST) ? '0 : slot_q + 1'b1;
    assign take_slot = line_active ? slot_next : slot_q;
    assign take_line = line_start && !repeat_line &&
                       (pend_cnt - PEND_W'(line_active)) != '0;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pend_cnt    <= '0;
            first_flags <= '0;
            slot_q      <= '0;
            line_active <= 1'b0;
            second_copy <= 1'b0;
            show_first  <= 1'b0;
        end else begin
            if (done.strobe) begin
                first_flags[done.slot[IDX_W-1:0]] <= done.first_of_frame;
            end
            pend_cnt <= pend_cnt + PEND_W'(done.strobe) - PEND_W'(release_line);
            if (release_line) begin
                slot_q <= slot_next;
            end
            if (line_start) begin
                if (repeat_line) begin
                    second_copy <= 1'b1;
                end else begin
                    line_active <= take_line;
                    second_copy <= 1'b0;
                    show_first  <= first_flags[take_slot[IDX_W-1:0]];
                end
            end
        end
    end

    ////////////////////////////////////////
    // reads and video out
    ////////////////////////////////////////

    // address leads de by the ram latency
    assign rd_slot = slot_q;
    assign rd_x = X_W'(h_cnt) - X_W'(ACT_START);

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hsync_q <= 1'b1;
            vsync_q <= 1'b1;
            de_q    <= 1'b0;
            dim_q   <= 1'b0;
        end else begin
            hsync_q <= state != OUT_SYNC;
            // frame start marked on the first copy only
            vsync_q <= !(state == OUT_SYNC && line_active && show_first && !second_copy);
            de_q    <= state == OUT_ACTIVE;
            dim_q   <= second_copy && scanline_en;
        end
    end

    // scanline copy at half intensity
    assign pixel_dim.red   = rd_pixel.red >> 1;
    assign pixel_dim.green = rd_pixel.green >> 1;
    assign pixel_dim.blue  = rd_pixel.blue >> 1;

    assign video = '{
        hsync: hsync_q,
        vsync: vsync_q,
        de:    de_q,
        pixel: de_q ? (dim_q ? pixel_dim : rd_pixel) : '0
    };

endmodule

// ==== verilog/dc_line_doubler.sv ====
`timescale 1ns/100ps

module dc_line_doubler #(
    parameter int H_START         = 32,
    parameter int H_ACTIVE        = 640,
    parameter int V_START         = 16,
    parameter int V_ACTIVE        = 480,
    parameter int BUFFER_LINES    = 4,
    parameter int OUT_LINE_CYCLES = 858,
    parameter int OUT_SYNC_CYCLES = 62
) (
    input  logic                           control_clock,
    input  logic                           reset_dc,
    input  logic                           hsync_n,
    input  logic                           vsync_n,
    input  logic [doubler_pkg::DATA_W-1:0] data,
    input  logic                           line_double,
    input  logic                           scanline_en,
    output doubler_pkg::video_out_t        video
);
    import doubler_pkg::*;

    buffer_write_t     wr;
    rgb_pixel_t        wr_pixel;
    line_done_t        done;
    logic [SLOT_W-1:0] rd_slot;
    logic [X_W-1:0]    rd_x;
    rgb_pixel_t        rd_pixel;

    ////////////////////////////////////////
    // capture, ring, raster out
    ////////////////////////////////////////

    video_capture #(
        .H_START      (H_START),
        .H_ACTIVE     (H_ACTIVE),
        .V_START      (V_START),
        .V_ACTIVE     (V_ACTIVE),
        .BUFFER_LINES (BUFFER_LINES)
    ) video_capture_i (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .hsync_n       (hsync_n),
        .vsync_n       (vsync_n),
        .data          (data),
        .wr            (wr),
        .wr_pixel      (wr_pixel),
        .done          (done)
    );

    line_buffer #(
        .H_ACTIVE     (H_ACTIVE),
        .BUFFER_LINES (BUFFER_LINES)
    ) line_buffer_i (
        .control_clock (control_clock),
        .wr            (wr),
        .wr_pixel      (wr_pixel),
        .rd_slot       (rd_slot),
        .rd_x          (rd_x),
        .rd_pixel      (rd_pixel)
    );

    video_output #(
        .H_ACTIVE        (H_ACTIVE),
        .BUFFER_LINES    (BUFFER_LINES),
        .OUT_LINE_CYCLES (OUT_LINE_CYCLES),
        .OUT_SYNC_CYCLES (OUT_SYNC_CYCLES)
    ) video_output_i (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .done          (done),
        .line_double   (line_double),
        .scanline_en   (scanline_en),
        .rd_slot       (rd_slot),
        .rd_x          (rd_x),
        .rd_pixel      (rd_pixel),
        .video         (video)
    );

endmodule

// ==== verilog/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer #(
    parameter int H_ACTIVE     = 640,
    parameter int BUFFER_LINES = 4
) (
    input  logic                           control_clock,
    input  doubler_pkg::buffer_write_t     wr,
    input  doubler_pkg::rgb_pixel_t        wr_pixel,
    input  logic [doubler_pkg::SLOT_W-1:0] rd_slot,
    input  logic [doubler_pkg::X_W-1:0]    rd_x,
    output doubler_pkg::rgb_pixel_t        rd_pixel
);
    import doubler_pkg::*;

    localparam int DEPTH = BUFFER_LINES * H_ACTIVE;
    localparam int ADDR_W = $clog2(DEPTH);

    // one line per slot, H_ACTIVE pixels each
    rgb_pixel_t mem [DEPTH];

    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    assign wr_addr = ADDR_W'(int'(wr.slot) * H_ACTIVE + int'(wr.x));
    assign rd_addr = ADDR_W'(int'(rd_slot) * H_ACTIVE + int'(rd_x));

    ////////////////////////////////////////
    // ram
    ////////////////////////////////////////

    // read returns old data on a same-address write
    always_ff @(posedge control_clock) begin
        if (wr.wren) begin
            mem[wr_addr] <= wr_pixel;
        end
        rd_pixel <= mem[rd_addr];
    end

endmodule
